//--- design/noc_packet_pkg.sv
// ##############################
// NoC packet format
// Field widths and the 64-bit packet word
// moved on every router port
// ##############################

package noc_packet_pkg;

  localparam int TAG_WIDTH     = 1;   // Marks a real packet
  localparam int RSVD_WIDTH    = 15;  // Spare header bits
  localparam int HOP_WIDTH     = 8;   // Ring hops still to go
  localparam int SRC_WIDTH     = 8;   // Sender identifier
  localparam int PAYLOAD_WIDTH = 32;

  // Header sits in the upper 32 bits and payload in the lower 32
  typedef struct packed {
    logic [TAG_WIDTH-1:0]     valid_tag;  // Always set by the sender
    logic [RSVD_WIDTH-1:0]    reserved;
    logic [HOP_WIDTH-1:0]     hop_count;  // Zero means deliver to the PE
    logic [SRC_WIDTH-1:0]     src_id;
    logic [PAYLOAD_WIDTH-1:0] payload;
  } packet_t;

endpackage

//--- design/noc_ctrl_pkg.sv
// ##############################
// NoC router control types
// Routing decision, arbiter state and
// the request an input channel offers
// ##############################

package noc_ctrl_pkg;

  // Output port chosen by the hop-count rule
  typedef enum logic {
    port_ring = 1'b0,  // Forward to downstream neighbor
    port_pe   = 1'b1   // Deliver to local PE
  } out_port_e;

  // Last input that won an output channel
  typedef enum logic {
    grant_ring_in = 1'b0,
    grant_pe_in   = 1'b1
  } grant_e;

  typedef struct packed {
    logic                      valid;  // Inner slot holds a packet
    out_port_e                 dest;
    noc_packet_pkg::packet_t   pkt;    // Hop count already updated
  } route_req_t;

endpackage

//--- design/router_input_channel.sv
// ##############################
// Router input channel
// Two virtual-channel slots. Outer slot
// follows polarity and the other is routed
// ##############################

`timescale 1ns/1ps

module router_input_channel (
  input  logic                    clk,
  input  logic                    reset,     // Synchronous, active high
  input  logic                    polarity,  // Selects the outer slot
  input  logic                    send,      // Sender offers data
  input  noc_packet_pkg::packet_t data,
  input  logic                    grant,     // Inner slot taken by an arbiter
  output logic                    ready,     // Outer slot can take a packet
  output noc_ctrl_pkg::route_req_t req
);

  noc_packet_pkg::packet_t slot_q [2];  // Virtual-channel storage
  logic [1:0]              full_q;      // One flag per slot
  logic                    accept_en_q; // Held low through reset
  logic                    take;        // Transfer on this edge
  logic                    inner;       // Slot index seen by the arbiters
  noc_packet_pkg::packet_t inner_pkt;

  assign inner = ~polarity;
  assign inner_pkt = slot_q[inner];

  // Ready depends only on registered state
  assign ready = accept_en_q & ~full_q[polarity];
  assign take  = send & ready;

  // Opens the port one cycle after reset is released
  always_ff @(posedge clk) begin
    if (reset)
      accept_en_q <= 1'b0;
    else
      accept_en_q <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      full_q <= 2'b00;
    end else begin
      if (take)
        full_q[polarity] <= 1'b1;  // Outer side fills
      if (grant)
        full_q[inner] <= 1'b0;     // Inner side drains
    end
  end

  // Payload storage carries no reset
  always_ff @(posedge clk) begin
    if (take)
      slot_q[polarity] <= data;
  end

  // Hop rule applied on the way out of the slot
  always_comb begin
    req.valid = full_q[inner];
    req.pkt   = inner_pkt;
    if (inner_pkt.hop_count == '0) begin
      req.dest = noc_ctrl_pkg::port_pe;  // Arrived
    end else begin
      req.dest = noc_ctrl_pkg::port_ring;
      req.pkt.hop_count = inner_pkt.hop_count - noc_packet_pkg::HOP_WIDTH'(1);
    end
  end

endmodule

//--- design/router_output_arbiter.sv
// ##############################
// Router output arbiter
// Round robin between ring and PE inputs
// for one output channel
// ##############################

`timescale 1ns/1ps

module router_output_arbiter (
  input  logic clk,
  input  logic reset,           // Synchronous, active high
  input  logic ring_req_valid,  // Ring input wants this port
  input  logic pe_req_valid,    // PE input wants this port
  input  logic slot_free,       // Output channel can load
  output logic ring_grant,
  output logic pe_grant
);

  noc_ctrl_pkg::grant_e last_q;  // Winner of the previous grant
  logic                 ring_turn;
  logic                 pe_turn;

  // On a tie the input that lost last time goes first
  assign ring_turn = (last_q == noc_ctrl_pkg::grant_pe_in);
  assign pe_turn   = (last_q == noc_ctrl_pkg::grant_ring_in);

  always_comb begin
    ring_grant = 1'b0;
    pe_grant   = 1'b0;
    if (slot_free) begin
      if (ring_req_valid && pe_req_valid) begin
        ring_grant = ring_turn;  // Contention
        pe_grant   = pe_turn;
      end else begin
        ring_grant = ring_req_valid;
        pe_grant   = pe_req_valid;
      end
    end
  end

  // State moves only when someone wins
  always_ff @(posedge clk) begin
    if (reset)
      last_q <= noc_ctrl_pkg::grant_pe_in;  // Ring wins first tie
    else if (ring_grant)
      last_q <= noc_ctrl_pkg::grant_ring_in;
    else if (pe_grant)
      last_q <= noc_ctrl_pkg::grant_pe_in;
  end

endmodule

//--- design/router_output_channel.sv
// ##############################
// Router output channel
// Two virtual-channel slots. Inner slot is
// loaded by the arbiter and outer one sent
// ##############################

`timescale 1ns/1ps

module router_output_channel (
  input  logic                    clk,
  input  logic                    reset,     // Synchronous, active high
  input  logic                    polarity,  // Outer slot index
  input  logic                    ready,     // Receiver can take a packet
  input  logic                    load,      // Arbiter granted a packet
  input  noc_packet_pkg::packet_t data_in,
  output logic                    slot_free, // Inner slot is empty
  output logic                    send,
  output noc_packet_pkg::packet_t data_out
);

  noc_packet_pkg::packet_t slot_q [2];
  logic [1:0]              full_q;  // Replaces the zero-data test
  logic                    inner;   // Slot written this cycle

  assign inner = ~polarity;

  assign slot_free = ~full_q[inner];

  // Send only toward a ready receiver
  assign send = full_q[polarity] & ready;

  // Bus stays at zero between packets
  assign data_out = send ? slot_q[polarity] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      full_q <= 2'b00;
    end else begin
      if (load)
        full_q[inner] <= 1'b1;
      if (send)
        full_q[polarity] <= 1'b0;  // Space again for the next packet
    end
  end

  // Packet storage
  always_ff @(posedge clk) begin
    if (load)
      slot_q[inner] <= data_in;
  end

  // Earliest send of a loaded slot is next cycle when polarity flips

endmodule

//--- design/ring_router.sv
// ##############################
// Ring router node
// Two inputs and two outputs joined by
// per-output round-robin arbiters
// ##############################

`timescale 1ns/1ps

module ring_router (
  input  logic                    clk,
  input  logic                    reset,           // Synchronous, active high
  output logic                    polarity,        // Flips every clock
  input  logic                    ring_in_send,
  input  noc_packet_pkg::packet_t ring_in_data,
  output logic                    ring_in_ready,
  input  logic                    pe_in_send,
  input  noc_packet_pkg::packet_t pe_in_data,
  output logic                    pe_in_ready,
  input  logic                    ring_out_ready,
  output logic                    ring_out_send,
  output noc_packet_pkg::packet_t ring_out_data,
  input  logic                    pe_out_ready,
  output logic                    pe_out_send,
  output noc_packet_pkg::packet_t pe_out_data
);

  noc_ctrl_pkg::route_req_t ring_in_req, pe_in_req;
  logic ring_arb_ring_grant, ring_arb_pe_grant;  // Grants for ring output
  logic pe_arb_ring_grant, pe_arb_pe_grant;      // Grants for PE output
  logic ring_out_free, pe_out_free;
  noc_packet_pkg::packet_t ring_out_pkt, pe_out_pkt;

  always_ff @(posedge clk) begin
    if (reset)
      polarity <= 1'b0;
    else
      polarity <= ~polarity;
  end

  router_input_channel u_ring_in (
    .clk, .reset, .polarity,
    .send  (ring_in_send),
    .data  (ring_in_data),
    .grant (ring_arb_ring_grant | pe_arb_ring_grant),  // One dest per request
    .ready (ring_in_ready),
    .req   (ring_in_req)
  );

  router_input_channel u_pe_in (
    .clk, .reset, .polarity,
    .send  (pe_in_send),
    .data  (pe_in_data),
    .grant (ring_arb_pe_grant | pe_arb_pe_grant),
    .ready (pe_in_ready),
    .req   (pe_in_req)
  );

  // Requests split by destination
  router_output_arbiter u_ring_arb (
    .clk, .reset,
    .ring_req_valid (ring_in_req.valid && ring_in_req.dest == noc_ctrl_pkg::port_ring),
    .pe_req_valid   (pe_in_req.valid && pe_in_req.dest == noc_ctrl_pkg::port_ring),
    .slot_free      (ring_out_free),
    .ring_grant     (ring_arb_ring_grant),
    .pe_grant       (ring_arb_pe_grant)
  );

  router_output_arbiter u_pe_arb (
    .clk, .reset,
    .ring_req_valid (ring_in_req.valid && ring_in_req.dest == noc_ctrl_pkg::port_pe),
    .pe_req_valid   (pe_in_req.valid && pe_in_req.dest == noc_ctrl_pkg::port_pe),
    .slot_free      (pe_out_free),
    .ring_grant     (pe_arb_ring_grant),
    .pe_grant       (pe_arb_pe_grant)
  );

  // Granted packet steered into each output
  assign ring_out_pkt = ring_arb_pe_grant ? pe_in_req.pkt : ring_in_req.pkt;
  assign pe_out_pkt   = pe_arb_pe_grant ? pe_in_req.pkt : ring_in_req.pkt;

  router_output_channel u_ring_out (
    .clk, .reset, .polarity,
    .ready     (ring_out_ready),
    .load      (ring_arb_ring_grant | ring_arb_pe_grant),
    .data_in   (ring_out_pkt),
    .slot_free (ring_out_free),
    .send      (ring_out_send),
    .data_out  (ring_out_data)
  );

  router_output_channel u_pe_out (
    .clk, .reset, .polarity,
    .ready     (pe_out_ready),
    .load      (pe_arb_ring_grant | pe_arb_pe_grant),
    .data_in   (pe_out_pkt),
    .slot_free (pe_out_free),
    .send      (pe_out_send),
    .data_out  (pe_out_data)
  );

endmodule

//--- tests/ring_router_assertions.sv
// ##############################
// Ring router protocol assertions
// Send/ready rule, PE routing, reset state
// ##############################

`timescale 1ns/1ps

module ring_router_assertions (
  input logic                    clk,
  input logic                    reset,
  input logic                    polarity,
  input logic                    ring_in_ready,
  input logic                    pe_in_ready,
  input logic                    ring_out_send,
  input logic                    ring_out_ready,
  input logic                    pe_out_send,
  input logic                    pe_out_ready,
  input noc_packet_pkg::packet_t pe_out_data
);

  int assert_fails;  // Failed assertion count

  ring_send_ready: assert property (@(posedge clk) ring_out_send |-> ring_out_ready)
    else begin
      $error("ring_out_send raised without ring_out_ready");
      assert_fails++;
    end

  pe_send_ready: assert property (@(posedge clk) pe_out_send |-> pe_out_ready)
    else begin
      $error("pe_out_send raised without pe_out_ready");
      assert_fails++;
    end

  // Only arrived packets reach the PE
  pe_hop_zero: assert property (@(posedge clk) pe_out_send |-> pe_out_data.hop_count == '0)
    else begin
      $error("packet with non-zero hop count delivered to the PE");
      assert_fails++;
    end

  // Checked from the second reset edge, once the registers are known
  reset_quiet: assert property (@(posedge clk) reset ##1 reset |->
      !polarity && !ring_in_ready && !pe_in_ready && !ring_out_send && !pe_out_send)
    else begin
      $error("router output active while in reset");
      assert_fails++;
    end

endmodule

bind ring_router ring_router_assertions u_assertions (
  .clk            (clk),
  .reset          (reset),
  .polarity       (polarity),
  .ring_in_ready  (ring_in_ready),
  .pe_in_ready    (pe_in_ready),
  .ring_out_send  (ring_out_send),
  .ring_out_ready (ring_out_ready),
  .pe_out_send    (pe_out_send),
  .pe_out_ready   (pe_out_ready),
  .pe_out_data    (pe_out_data)
);

//--- tests/ring_router_tb.sv
// ##############################
// Ring router testbench
// Random traffic from both inputs checked
// against a hop-rule model per flow
// ##############################

`timescale 1ns/1ps

module ring_router_tb;

  localparam int NUM_PKTS       = 200;       // Per input source
  localparam int TIMEOUT_CYCLES = 400 * 20;  // Packets times a generous per-packet budget

  logic                    clk;
  logic                    reset;
  logic                    polarity;
  logic                    ring_in_send, ring_in_ready, pe_in_send, pe_in_ready;
  noc_packet_pkg::packet_t ring_in_data, pe_in_data;
  logic                    ring_out_ready, ring_out_send, pe_out_ready, pe_out_send;
  noc_packet_pkg::packet_t ring_out_data, pe_out_data;

  noc_packet_pkg::packet_t exp_q [8][$];  // Per source, output port and virtual channel
  int   errors, checks, accepted, sends, cycle, sources_done;
  int   seq_no [2];           // Next payload per source
  int   accept_cycle [2];     // Edge of the last transfer per source
  int   last_send_cycle [2];  // Edge of the last send per output
  logic prev_pol;
  bit   pol_armed;

  ring_router DUT (.*);

  always #20 clk = ~clk;

  function automatic noc_packet_pkg::packet_t make_pkt(input int src, input int hop,
                                                        input int seq);
    noc_packet_pkg::packet_t p;
    p           = '0;
    p.valid_tag = 1'b1;
    p.hop_count = noc_packet_pkg::HOP_WIDTH'(hop);
    p.src_id    = 8'(src);
    p.payload   = noc_packet_pkg::PAYLOAD_WIDTH'(seq);  // Sequence number
    return p;
  endfunction

  // Model of one hop: a packet that has not arrived loses one from its count
  function automatic noc_packet_pkg::packet_t forward_pkt(input noc_packet_pkg::packet_t p);
    noc_packet_pkg::packet_t q;
    q = p;
    if (p.hop_count != 0)
      q.hop_count = p.hop_count - 1;
    return q;
  endfunction

  // Queue index from source, output port (1 is the PE) and virtual channel
  function automatic int flow_index(input int src, input int port, input int vc);
    return (src * 2 + port) * 2 + vc;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    checks++;
    assert (act_val === exp_val) else begin
      errors++;
      $display("error: time %0t %s expected %h actual %h", $time, name, exp_val, act_val);
    end
  endtask

  task automatic check_idle_outputs();
    check_value("polarity", 0, polarity);
    check_value("ring_in_ready", 0, ring_in_ready);
    check_value("pe_in_ready", 0, pe_in_ready);
    check_value("ring_out_send", 0, ring_out_send);
    check_value("pe_out_send", 0, pe_out_send);
  endtask

  task automatic record_accept(input int src, input noc_packet_pkg::packet_t pkt);
    int dest;
    dest = (pkt.hop_count == 0) ? 1 : 0;  // Hop count zero goes to the PE
    // Packets keep their order only within the slot chosen by polarity
    exp_q[flow_index(src, dest, polarity)].push_back(forward_pkt(pkt));
    accept_cycle[src] = cycle + 1;  // Transfer happens on the coming edge
    accepted++;
  endtask

  // Holds send until ready is seen for the coming rising edge
  task automatic offer_packet(input int src, input noc_packet_pkg::packet_t pkt);
    bit taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      if (src == 0) begin
        ring_in_send = 1'b1;
        ring_in_data = pkt;
        taken        = ring_in_ready;  // Input ready only moves on the rising edge
      end else begin
        pe_in_send = 1'b1;
        pe_in_data = pkt;
        taken      = pe_in_ready;
      end
    end
    record_accept(src, pkt);
  endtask

  task automatic idle_source(input int src);
    @(negedge clk);
    if (src == 0) begin
      ring_in_send = 1'b0;
      ring_in_data = '0;
    end else begin
      pe_in_send = 1'b0;
      pe_in_data = '0;
    end
  endtask

  task automatic run_source(input int src);
    noc_packet_pkg::packet_t pkt;
    for (int i = 0; i < NUM_PKTS; i++) begin
      pkt = make_pkt(src, $urandom_range(3), seq_no[src]);
      seq_no[src]++;
      offer_packet(src, pkt);
      if ($urandom_range(3) == 0)
        idle_source(src);  // Occasional gap
    end
    idle_source(src);
    sources_done++;
  endtask

  task automatic toggle_out_ready();
    while (sources_done < 2) begin
      @(negedge clk);
      ring_out_ready = ($urandom_range(99) < 70);  // About 70% high
      pe_out_ready   = ($urandom_range(99) < 70);
    end
    ring_out_ready = 1'b1;  // Drain without back-pressure
    pe_out_ready   = 1'b1;
  endtask

  // Single packet in flight with both outputs ready
  task automatic check_min_latency(input int src, input int hop);
    noc_packet_pkg::packet_t pkt;
    int port;
    int target;
    pkt = make_pkt(src, hop, seq_no[src]);
    seq_no[src]++;
    port   = (hop == 0) ? 1 : 0;
    target = sends + 1;
    offer_packet(src, pkt);
    idle_source(src);
    while (sends < target)
      @(negedge clk);
    check_value("latency", 2, last_send_cycle[port] - accept_cycle[src]);
  endtask

  // Each send must match the head of its flow queue
  task automatic check_output(input int port, input noc_packet_pkg::packet_t data);
    string name;
    int idx;
    noc_packet_pkg::packet_t exp_pkt;
    name = (port == 1) ? "pe_out_data" : "ring_out_data";
    sends++;
    last_send_cycle[port] = cycle;
    idx = flow_index(data.src_id, port, polarity);  // Sent from the polarity slot
    checks++;
    assert (idx < 8 && exp_q[idx].size() > 0) else begin
      errors++;
      $display("%s sent a packet that matches no accepted packet at time %0t", name, $time);
    end
    if (idx < 8 && exp_q[idx].size() > 0) begin
      exp_pkt = exp_q[idx].pop_front();
      check_value(name, exp_pkt, data);
    end
  endtask

  // Output monitor and cycle limit
  always @(posedge clk) begin
    cycle++;
    if (cycle > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d of %0d packets sent", cycle, sends, accepted);
      $display("TEST FAIL");
      $finish;
    end else begin
      if (!reset) begin
        if (pol_armed)
          check_value("polarity", !prev_pol, polarity);  // Flips every edge
        prev_pol  = polarity;
        pol_armed = 1'b1;
      end
      if (ring_out_send)
        check_output(0, ring_out_data);
      if (pe_out_send)
        check_output(1, pe_out_data);
    end
  end

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    ring_in_send   = 1'b0;
    ring_in_data   = '0;
    pe_in_send     = 1'b0;
    pe_in_data     = '0;
    ring_out_ready = 1'b0;
    pe_out_ready   = 1'b0;
    void'($urandom(32'h2df0_4876));
    repeat (4) begin
      @(negedge clk);
      check_idle_outputs();  // After each reset edge
    end
    reset = 1'b0;
    check_idle_outputs();  // State seen by the first edge after reset
    ring_out_ready = 1'b1;
    pe_out_ready   = 1'b1;
    check_min_latency(0, 0);  // Ring in to PE out
    check_min_latency(1, 2);  // PE in to ring out
    fork
      run_source(0);
      run_source(1);
      toggle_out_ready();
    join
    while (sends < accepted)
      @(negedge clk);
    repeat (10) @(negedge clk);  // Window for a stray duplicate
    for (int i = 0; i < 8; i++) begin
      checks++;
      assert (exp_q[i].size() == 0) else begin
        errors++;
        $display("flow %0d still holds %0d undelivered packets", i, exp_q[i].size());
      end
    end
    check_value("send count", accepted, sends);
    errors += DUT.u_assertions.assert_fails;  // Bound protocol assertions
    $display("checks %0d errors %0d accepted %0d sent %0d", checks, errors, accepted, sends);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- tb.f
design/noc_packet_pkg.sv
design/noc_ctrl_pkg.sv
design/router_input_channel.sv
design/router_output_arbiter.sv
design/router_output_channel.sv
design/ring_router.sv
tests/ring_router_assertions.sv
tests/ring_router_tb.sv

//--- Bender.yml
package:
  name: ring_router

sources:
  - files:
      - design/noc_packet_pkg.sv
      - design/noc_ctrl_pkg.sv
      - design/router_input_channel.sv
      - design/router_output_arbiter.sv
      - design/router_output_channel.sv
      - design/ring_router.sv
  - target: test
    files:
      - tests/ring_router_assertions.sv
      - tests/ring_router_tb.sv
